//--- files.f
logic/tart_cfg_pkg.sv
logic/tart_bus_pkg.sv
logic/hilbert_approx.sv
logic/bank_switch.sv
logic/correlator_block.sv
logic/visibility_bus.sv
logic/tart_correlator.sv
verif/tart_correlator_props.sv
verif/tb_tart_correlator.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   -f files.f --top-module tb_tart_correlator -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
   exit 0
fi
exit 1

//--- verif/tb_tart_correlator.sv
`timescale 1ns/1ps

module tb_tart_correlator
   import tart_cfg_pkg::*;
   import tart_bus_pkg::*;
();

   localparam int   NANT  = NANT_DEF;
   localparam int   NCNT  = 2 * CNT_PER_BLK;  // Counters over both blocks
   localparam int   LIMIT = 500;              // Cycles before a wait gives up
   localparam int   NRD   = 32;               // Back-to-back reads
   localparam adr_t ADR_BLKSIZE = 8'h80;
   localparam adr_t ADR_BANK    = 8'h81;

   logic            clk_i, rst, en_i, req_i, we_i, ack_o, err_o;
   logic [NANT-1:0] ant_i;
   adr_t            adr_i;
   dat_t            dat_i, dat_o;
   bank_t           bank_o;
   int              errors, tests, bad_tests;

   // Reference model state
   logic [NANT-1:0] m_new, m_old;     // Two-sample history
   bit              m_primed, m_valid;
   int unsigned     m_acc [NCNT];
   int unsigned     m_frz [NCNT];     // Last finished block
   int unsigned     m_cnt, m_bank, m_blk, m_swaps;

   tart_correlator #(.NANT(NANT)) u_dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // ------------------------------
   // Model
   // ------------------------------
   // Counter c is pair c/2, part c%2 (real, then imaginary)
   function automatic int unsigned agrees(int c, logic [NANT-1:0] re, logic [NANT-1:0] im);
      int a;
      int b;
      a = PAIR_A[c / 2];
      b = PAIR_B[c / 2];
      if (c % 2 == 0)
         return (re[a] == re[b]) ? 1 : 0;
      return (re[a] == im[b]) ? 1 : 0;
   endfunction

   always @(posedge clk_i) begin : model
      bit close;
      if (rst) begin
         m_primed = 0;
         m_valid  = 0;
         m_cnt    = 0;
         m_bank   = 0;
         m_swaps  = 0;
         m_blk    = 15;  // Block size after reset
         for (int c = 0; c < NCNT; c++) begin
            m_acc[c] = 0;
            m_frz[c] = 0;
         end
      end else begin
         if (m_valid) begin
            close = (m_cnt == m_blk);  // Last sample of the block
            for (int c = 0; c < NCNT; c++) begin
               if (close) begin
                  m_frz[c] = m_acc[c] + agrees(c, m_new, m_old);
                  m_acc[c] = 0;
               end else
                  m_acc[c] += agrees(c, m_new, m_old);
            end
            if (close) begin
               m_cnt   = 0;
               m_bank  = (m_bank + 1) % (1 << BANK_W_DEF);
               m_swaps++;
            end else
               m_cnt++;
         end
         if (req_i && we_i && adr_i == ADR_BLKSIZE)
            m_blk = dat_i;  // Applies from the next compare
         m_valid = en_i && m_primed;
         if (en_i) begin
            m_primed = 1;
            m_old    = m_new;
            m_new    = ant_i;
         end
      end
   end

   function automatic int unsigned model_read(adr_t adr);
      if (adr[7:6] == 2'd2)
         return (adr[5:0] == 0) ? m_blk : m_bank;
      if (adr[2:0] >= CNT_PER_BLK)
         return 0;  // Unused indices
      return m_frz[adr[7:6] * CNT_PER_BLK + adr[2:0]];
   endfunction

   function automatic adr_t cnt_adr(int c);
      return adr_t'(((c / CNT_PER_BLK) << 6) + c % CNT_PER_BLK);
   endfunction

   function automatic adr_t rand_mapped_adr();
      int unsigned unit;
      unit = $urandom % 3;
      if (unit == 2)
         return adr_t'(ADR_BLKSIZE + $urandom % 2);
      return adr_t'((unit << 6) + $urandom % 8);
   endfunction

   // ------------------------------
   // Checks and bus
   // ------------------------------
   task automatic check_value(string name, int unsigned exp, int unsigned act);
      if (exp !== act) begin
         errors++;
         $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      end
   endtask

   task automatic end_test(string name, int e0);
      tests++;
      if (errors != e0) begin
         bad_tests++;
         $display("%-12s FAIL, %0d problems", name, errors - e0);
      end else
         $display("%-12s ok", name);
   endtask

   task automatic bus_access(bit we, adr_t adr, dat_t wdat, output bit ack, output bit err);
      int n;
      @(negedge clk_i);
      req_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      dat_i = wdat;
      @(negedge clk_i);
      req_i = 1'b0;
      n = 1;
      while (!(ack_o || err_o) && n < LIMIT) begin
         @(negedge clk_i);
         n++;
      end
      if (!(ack_o || err_o)) begin
         errors++;
         $display("No bus response to address 0x%0h within %0d cycles", adr, LIMIT);
      end else
         check_value("response latency", 2, n);  // Cycles since the request
      ack = ack_o;
      err = err_o;
   endtask

   task automatic read_expect(adr_t adr, int unsigned exp, string name);
      bit ack;
      bit err;
      bus_access(1'b0, adr, '0, ack, err);
      check_value({name, " ack_o"}, 1, ack);
      check_value({name, " err_o"}, 0, err);
      check_value({name, " dat_o"}, exp, dat_o);
   endtask

   task automatic expect_error(bit we, adr_t adr, int unsigned held, string name);
      bit ack;
      bit err;
      bus_access(we, adr, dat_t'($urandom), ack, err);
      check_value({name, " err_o"}, 1, err);
      check_value({name, " ack_o"}, 0, ack);
      check_value({name, " dat_o"}, held, dat_o);  // Old data kept
   endtask

   // ------------------------------
   // Sample stream
   // ------------------------------
   task automatic sample_cycle();
      @(negedge clk_i);
      check_value("bank_o", m_bank, bank_o);
      en_i  = 1'($urandom % 2);
      ant_i = NANT'($urandom);
   endtask

   // Stops the stream and lets the valid pipe drain
   task automatic settle();
      @(negedge clk_i);
      en_i = 1'b0;
      repeat (2) @(negedge clk_i);
   endtask

   task automatic wait_swaps(int unsigned k);
      int unsigned target;
      int          n;
      target = m_swaps + k;
      n = 0;
      while (m_swaps < target && n < LIMIT) begin
         sample_cycle();
         n++;
      end
      if (m_swaps < target) begin
         errors++;
         $display("Block swap did not come within %0d cycles", LIMIT);
      end
      settle();
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      bit          ack, err;
      int          e0;
      int unsigned bs, held;
      int unsigned snap [NCNT];
      int unsigned q_exp [$];
      adr_t        a;
      void'($urandom(32'h69ff_791a));
      {rst, en_i, req_i, we_i} = 4'b1000;
      ant_i = '0;
      adr_i = '0;
      dat_i = '0;
      repeat (3) @(negedge clk_i);
      rst = 1'b0;

      e0 = errors;
      read_expect(ADR_BANK, 0, "BANK");
      read_expect(ADR_BLKSIZE, 15, "BLKSIZE");
      for (int c = 0; c < NCNT; c++)
         read_expect(cnt_adr(c), 0, $sformatf("cnt%0d", c));
      end_test("reset_state", e0);

      e0 = errors;
      bs = 3 + $urandom % 18;
      bus_access(1'b1, ADR_BLKSIZE, dat_t'(bs), ack, err);
      check_value("BLKSIZE write ack_o", 1, ack);
      read_expect(ADR_BLKSIZE, bs, "BLKSIZE");
      wait_swaps(3);  // bank_o checked every cycle
      end_test("block_size", e0);

      e0 = errors;
      for (int c = 0; c < NCNT; c++)
         read_expect(cnt_adr(c), m_frz[c], $sformatf("cnt%0d", c));
      end_test("visibility", e0);

      e0 = errors;
      for (int k = 0; k < NRD + 2; k++) begin
         @(negedge clk_i);
         check_value("err_o", 0, err_o);
         check_value("ack_o", (k >= 2) ? 1 : 0, ack_o);
         if (k >= 2)
            check_value("dat_o", q_exp.pop_front(), dat_o);  // Request from k-2
         req_i = (k < NRD);
         we_i  = 1'b0;
         if (k < NRD) begin
            a = rand_mapped_adr();
            adr_i = a;
            q_exp.push_back(model_read(a));
         end
      end
      end_test("pipelined", e0);

      e0 = errors;
      read_expect(cnt_adr(1), m_frz[1], "cnt1");
      held = dat_o;
      expect_error(1'b0, adr_t'(8'hC0 + $urandom % 64), held, "unit 3 read");
      expect_error(1'b1, cnt_adr(0), held, "block 0 write");
      expect_error(1'b1, cnt_adr(CNT_PER_BLK + 2), held, "block 1 write");
      expect_error(1'b1, ADR_BANK, held, "BANK write");
      read_expect(ADR_BANK, m_bank, "BANK");
      end_test("errors", e0);

      // One sample into a fresh block, short of any boundary
      e0 = errors;
      wait_swaps(1);
      snap = m_frz;
      @(negedge clk_i);
      en_i  = 1'b1;
      ant_i = NANT'($urandom);
      settle();
      check_value("bank_o mid-block", m_bank, bank_o);
      for (int c = 0; c < NCNT; c++)
         read_expect(cnt_adr(c), snap[c], $sformatf("frozen cnt%0d", c));
      end_test("freeze", e0);

      $display("%0d tests, %0d failed, %0d errors", tests, bad_tests, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

//--- verif/tart_correlator_props.sv
`timescale 1ns/1ps

module tart_correlator_props
   import tart_cfg_pkg::*;
(
   input logic  clk_i,
   input logic  rst,
   input logic  req_i,
   input logic  ack_i,
   input logic  err_i,
   input logic  swap_i,
   input bank_t bank_i
);

   // ------------------------------
   // Bus response
   // ------------------------------
   a_one_resp: assert property (@(posedge clk_i) disable iff (rst)
      !(ack_i && err_i)) else $error("ack and err high together");

   a_resp_lat: assert property (@(posedge clk_i) disable iff (rst)
      req_i |-> ##2 (ack_i || err_i)) else $error("request not answered in two cycles");

   // No answer without a request two cycles back
   a_no_extra: assert property (@(posedge clk_i) disable iff (rst)
      (ack_i || err_i) |-> $past(req_i, 2)) else $error("response without request");

   // ------------------------------
   // Block boundary
   // ------------------------------
   a_swap_pulse: assert property (@(posedge clk_i) disable iff (rst)
      swap_i |=> !swap_i) else $error("swap high two cycles in a row");

   a_bank_hold: assert property (@(posedge clk_i) disable iff (rst)
      !swap_i |=> $stable(bank_i)) else $error("bank moved without swap");

   a_bank_step: assert property (@(posedge clk_i) disable iff (rst)
      swap_i |=> bank_i == bank_t'($past(bank_i) + 1'b1)) else $error("bank did not step");

endmodule

bind tart_correlator tart_correlator_props u_props (
   .clk_i, .rst, .req_i,
   .ack_i  (ack_o),
   .err_i  (err_o),
   .swap_i (swap),
   .bank_i (bank)
);

//--- logic/tart_correlator.sv
`timescale 1ns/1ps

module tart_correlator
   import tart_cfg_pkg::*;
   import tart_bus_pkg::*;
#(
   parameter int NANT   = NANT_DEF,
   parameter int ACC_W  = ACC_W_DEF,
   parameter int BANK_W = BANK_W_DEF
) (
   input  logic            clk_i,
   input  logic            rst,
   input  logic            en_i,    // Antenna sample strobe
   input  logic [NANT-1:0] ant_i,
   input  logic            req_i,   // Register bus
   input  logic            we_i,
   input  adr_t            adr_i,
   input  dat_t            dat_i,
   output logic            ack_o,
   output logic            err_o,
   output dat_t            dat_o,
   output bank_t           bank_o
);

   logic [NANT-1:0] re, im;
   logic            smp_valid;
   logic            swap;
   count_t          blk_size;
   bank_t           bank;
   logic [1:0]      rd_sel;
   logic [2:0]      rd_idx;
   count_t          rd_dat [2];

   // ------------------------------
   // Sample path
   // ------------------------------
   hilbert_approx #(.NANT(NANT)) u_hilbert (
      .clk_i, .rst, .en_i, .ant_i,
      .re_o(re), .im_o(im), .valid_o(smp_valid)
   );

   bank_switch #(.ACC_W(ACC_W), .BANK_W(BANK_W)) u_bank_switch (
      .clk_i, .rst,
      .valid_i(smp_valid), .blk_size_i(blk_size),
      .swap_o(swap), .bank_o(bank)
   );

   // Both blocks share the boundary, each owns half the pairs
   for (genvar b = 0; b < 2; b++) begin : g_blk
      correlator_block #(.NANT(NANT), .ACC_W(ACC_W), .BLK_ID(b)) u_blk (
         .clk_i, .rst,
         .valid_i(smp_valid), .swap_i(swap),
         .re_i(re), .im_i(im),
         .rd_sel_i(rd_sel[b]), .rd_idx_i(rd_idx), .rd_dat_o(rd_dat[b])
      );
   end

   // ------------------------------
   // Register bus
   // ------------------------------
   visibility_bus #(.ACC_W(ACC_W)) u_bus (
      .clk_i, .rst, .req_i, .we_i, .adr_i, .dat_i,
      .ack_o, .err_o, .dat_o,
      .blk_size_o(blk_size), .bank_i(bank),
      .rd_sel_o(rd_sel), .rd_idx_o(rd_idx),
      .rd_dat0_i(rd_dat[0]), .rd_dat1_i(rd_dat[1])
   );

   assign bank_o = bank;

endmodule

//--- logic/visibility_bus.sv
`timescale 1ns/1ps

module visibility_bus
   import tart_cfg_pkg::*;
   import tart_bus_pkg::*;
#(
   parameter int ACC_W = ACC_W_DEF
) (
   input  logic       clk_i,
   input  logic       rst,
   input  logic       req_i,       // One access per cycle, never stalled
   input  logic       we_i,
   input  adr_t       adr_i,
   input  dat_t       dat_i,
   output logic       ack_o,
   output logic       err_o,
   output dat_t       dat_o,
   output count_t     blk_size_o,  // Block size - 1
   input  bank_t      bank_i,
   output logic [1:0] rd_sel_o,    // One select per block
   output logic [2:0] rd_idx_o,
   input  count_t     rd_dat0_i,
   input  count_t     rd_dat1_i
);

   unit_e            unit;
   logic [OFS_W-1:0] ofs;
   logic             bad;         // Unmapped or illegal access

   // Stage 1, decoded request
   logic  s1_vld_q, s1_err_q;
   logic  s1_rd_q;                // Read, so data returns
   logic  s1_bank_q;              // System read of BANK
   unit_e s1_unit_q;

   count_t blk_size_q;
   dat_t   rd_mux;

   // ------------------------------
   // Cycle 0, decode
   // ------------------------------
   assign unit = unit_e'(adr_i[ADR_W-1 -: UNIT_W]);
   assign ofs  = adr_i[OFS_W-1:0];

   always_comb begin
      case (unit)
         UNIT_BLK0, UNIT_BLK1: bad = we_i;  // Blocks are read-only
         UNIT_SYS: begin
            if (ofs == SYS_BANK)
               bad = we_i;
            else
               bad = (ofs != SYS_BLKSIZE);  // Hole in system space
         end
         default: bad = 1'b1;
      endcase
   end

   // Block reads go out now so the data lands for cycle 2
   assign rd_sel_o[0] = req_i & ~we_i & (unit == UNIT_BLK0);
   assign rd_sel_o[1] = req_i & ~we_i & (unit == UNIT_BLK1);
   assign rd_idx_o    = adr_i[IDX_W-1:0];

   always_ff @(posedge clk_i) begin
      if (rst) begin
         s1_vld_q <= 1'b0;
         s1_err_q <= 1'b0;
      end else begin
         s1_vld_q <= req_i;
         s1_err_q <= req_i & bad;
      end
      s1_rd_q   <= ~we_i;
      s1_unit_q <= unit;
      s1_bank_q <= (ofs == SYS_BANK);
   end

   // Top bit held clear so a full block cannot overflow a counter
   always_ff @(posedge clk_i) begin
      if (rst)
         blk_size_q <= BLK_SIZE_RST;
      else if (req_i & we_i & (unit == UNIT_SYS) & (ofs == SYS_BLKSIZE))
         blk_size_q <= count_t'({1'b0, dat_i[ACC_W-2:0]});
   end

   assign blk_size_o = blk_size_q;

   // ------------------------------
   // Cycle 1, data select
   // ------------------------------
   always_comb begin
      case (s1_unit_q)
         UNIT_BLK0: rd_mux = dat_t'(rd_dat0_i);
         UNIT_BLK1: rd_mux = dat_t'(rd_dat1_i);
         default:   rd_mux = s1_bank_q ? dat_t'(bank_i) : dat_t'(blk_size_q);
      endcase
   end

   // Response registered, out in cycle 2
   always_ff @(posedge clk_i) begin
      if (rst) begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
      end else begin
         ack_o <= s1_vld_q & ~s1_err_q;
         err_o <= s1_vld_q & s1_err_q;
      end
      if (s1_vld_q & ~s1_err_q & s1_rd_q)
         dat_o <= rd_mux;  // Held on writes and errors
   end

endmodule

//--- logic/correlator_block.sv
`timescale 1ns/1ps

module correlator_block
   import tart_cfg_pkg::*;
#(
   parameter int NANT   = NANT_DEF,
   parameter int ACC_W  = ACC_W_DEF,
   parameter int BLK_ID = 0         // Picks pairs from the tables
) (
   input  logic            clk_i,
   input  logic            rst,
   input  logic            valid_i,   // Sample strobe
   input  logic            swap_i,    // Block boundary
   input  logic [NANT-1:0] re_i,
   input  logic [NANT-1:0] im_i,
   input  logic            rd_sel_i,  // Read of this block
   input  logic [2:0]      rd_idx_i,  // pair*2 + part
   output count_t          rd_dat_o
);

   localparam int BASE = BLK_ID * PAIRS_PER_BLK;  // First global pair

   logic [CNT_PER_BLK-1:0] agree;            // Sign agreement per counter
   logic [ACC_W-1:0]       acc_q [CNT_PER_BLK];
   logic [ACC_W-1:0]       frz_q [CNT_PER_BLK];  // Last finished block
   logic [ACC_W-1:0]       sum   [CNT_PER_BLK];
   logic [ACC_W-1:0]       rd_mux;
   count_t                 rd_dat_q;

   // ------------------------------
   // Agreement per pair
   // ------------------------------
   // One-bit samples agree in sign when the bits are equal
   for (genvar p = 0; p < PAIRS_PER_BLK; p++) begin : g_pair
      localparam int ANT_A = PAIR_A[BASE + p];
      localparam int ANT_B = PAIR_B[BASE + p];

      assign agree[2*p]   = (re_i[ANT_A] == re_i[ANT_B]);  // Real x real
      assign agree[2*p+1] = (re_i[ANT_A] == im_i[ANT_B]);  // Real x imag
   end

   // Next count, with the current sample folded in
   for (genvar i = 0; i < CNT_PER_BLK; i++) begin : g_sum
      assign sum[i] = acc_q[i] + {{(ACC_W-1){1'b0}}, valid_i & agree[i]};
   end

   // ------------------------------
   // Accumulate and freeze
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst) begin
         for (int i = 0; i < CNT_PER_BLK; i++) begin
            acc_q[i] <= '0;
            frz_q[i] <= '0;
         end
      end else if (swap_i) begin
         // Finished block moves to readout, accumulators restart
         for (int i = 0; i < CNT_PER_BLK; i++) begin
            frz_q[i] <= sum[i];
            acc_q[i] <= '0;
         end
      end else if (valid_i) begin
         for (int i = 0; i < CNT_PER_BLK; i++) begin
            acc_q[i] <= sum[i];
         end
      end
   end

   // ------------------------------
   // Readout
   // ------------------------------
   // Indices past the last counter read as zero
   always_comb begin
      rd_mux = '0;
      for (int i = 0; i < CNT_PER_BLK; i++) begin
         if (rd_idx_i == 3'(i))
            rd_mux = frz_q[i];
      end
   end

   // Held between reads
   always_ff @(posedge clk_i) begin
      if (rd_sel_i)
         rd_dat_q <= count_t'(rd_mux);  // Ready the cycle after select
   end

   assign rd_dat_o = rd_dat_q;

endmodule

//--- logic/bank_switch.sv
`timescale 1ns/1ps

module bank_switch
   import tart_cfg_pkg::*;
#(
   parameter int ACC_W  = ACC_W_DEF,
   parameter int BANK_W = BANK_W_DEF
) (
   input  logic   clk_i,
   input  logic   rst,
   input  logic   valid_i,     // One valid sample this cycle
   input  count_t blk_size_i,  // Samples per block, minus one
   output logic   swap_o,      // Block boundary pulse
   output bank_t  bank_o
);

   logic [ACC_W-1:0]  smp_cnt_q;  // Valid samples so far in this block
   logic [BANK_W-1:0] bank_q;
   logic              last;       // This sample closes the block

   // ------------------------------
   // Block boundary
   // ------------------------------
   // Size is sampled at the compare, so a new size hits the open block
   assign last   = (smp_cnt_q == blk_size_i);
   assign swap_o = valid_i & last;

   // Sample counter
   always_ff @(posedge clk_i) begin
      if (rst) begin
         smp_cnt_q <= '0;
      end else if (valid_i) begin
         if (last)
            smp_cnt_q <= '0;  // Restart with the next block
         else
            smp_cnt_q <= smp_cnt_q + 1'b1;
      end
   end

   // ------------------------------
   // Bank index
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst)
         bank_q <= '0;
      else if (swap_o)
         bank_q <= bank_q + 1'b1;  // Wraps
   end

   // Visible the cycle after the swap
   assign bank_o = bank_q;

endmodule

//--- logic/hilbert_approx.sv
`timescale 1ns/1ps

module hilbert_approx #(
   parameter int NANT = 4
) (
   input  logic            clk_i,
   input  logic            rst,
   input  logic            en_i,    // Sample strobe
   input  logic [NANT-1:0] ant_i,   // One-bit samples, one per antenna
   output logic [NANT-1:0] re_o,
   output logic [NANT-1:0] im_o,
   output logic            valid_o
);

   logic [NANT-1:0] smp_new_q;  // Newest sample
   logic [NANT-1:0] smp_old_q;  // The one before it
   logic            primed_q;   // At least one sample taken
   logic            valid_q;

   // ------------------------------
   // Sample history
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         smp_new_q <= ant_i;
         smp_old_q <= smp_new_q;  // Shift down one
      end
   end

   // Valid only once both history slots hold real samples
   always_ff @(posedge clk_i) begin
      if (rst) begin
         primed_q <= 1'b0;
         valid_q  <= 1'b0;
      end else begin
         if (en_i)
            primed_q <= 1'b1;
         valid_q <= en_i & primed_q;  // Second and later samples
      end
   end

   // Quarter-period delay stands in for the 90 degree shift
   assign re_o    = smp_new_q;
   assign im_o    = smp_old_q;  // Previous sample as imaginary
   assign valid_o = valid_q;

endmodule

//--- logic/tart_bus_pkg.sv
package tart_bus_pkg;

   // ------------------------------
   // Address and data
   // ------------------------------
   parameter int ADR_W = 8;
   parameter int DAT_W = 16;

   typedef logic [ADR_W-1:0] adr_t;
   typedef logic [DAT_W-1:0] dat_t;

   // Unit field sits in the top address bits
   parameter int UNIT_W = 2;
   parameter int OFS_W  = ADR_W - UNIT_W;  // Offset inside a unit
   parameter int IDX_W  = 3;               // Counter select inside a block

   typedef enum logic [UNIT_W-1:0] {
      UNIT_BLK0 = 2'd0,  // Correlator block 0
      UNIT_BLK1 = 2'd1,  // Correlator block 1
      UNIT_SYS  = 2'd2,  // System registers
      UNIT_NONE = 2'd3   // Unmapped
   } unit_e;

   // System register offsets
   parameter logic [OFS_W-1:0] SYS_BLKSIZE = 6'd0;  // RW, block size - 1
   parameter logic [OFS_W-1:0] SYS_BANK    = 6'd1;  // RO, bank index

endpackage

//--- logic/tart_cfg_pkg.sv
package tart_cfg_pkg;

   // ------------------------------
   // Array defaults
   // ------------------------------
   parameter int NANT_DEF   = 4;   // Antennas
   parameter int ACC_W_DEF  = 16;  // Accumulator width, also caps block size
   parameter int BANK_W_DEF = 4;   // Bank index width

   // Visibility count, or the block size
   typedef logic [ACC_W_DEF-1:0]  count_t;
   // Bank index
   typedef logic [BANK_W_DEF-1:0] bank_t;

   // Block size after reset, minus one, so 16 samples per block
   parameter count_t BLK_SIZE_RST = count_t'(15);

   // ------------------------------
   // Baseline tables
   // ------------------------------
   parameter int PAIRS_PER_BLK = 3;
   parameter int NPAIRS        = 2 * PAIRS_PER_BLK;

   // Pair n correlates antenna PAIR_A[n] with antenna PAIR_B[n]
   // Block 0 owns pairs 0..2, block 1 owns pairs 3..5
   parameter int PAIR_A [0:NPAIRS-1] = '{0, 0, 0, 1, 1, 2};
   parameter int PAIR_B [0:NPAIRS-1] = '{1, 2, 3, 2, 3, 3};

   // Counters per block, a real and an imaginary one per pair
   parameter int CNT_PER_BLK = 2 * PAIRS_PER_BLK;

endpackage
